// File: fetch_pkg.sv
package fetch_pkg;

  // ==================================================
  // fetch geometry
  // ==================================================

  // pc and cache address width
  localparam int XLEN = 32;

  // one cache line, split into instruction words
  localparam int LINE_BITS      = 128;
  localparam int LINE_OFFSET    = 4;
  localparam int WORDS_PER_LINE = 4;

  // prefetch buffer, pointers carry one wrap bit
  localparam int FB_DEPTH    = 4;
  localparam int FB_PTR_BITS = 3;

  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // ==================================================
  // read port states
  // ==================================================
  localparam logic RD_IDLE = 1'b0;
  localparam logic RD_WAIT = 1'b1;

  // ==================================================
  // cache line, stored raw, selected per word
  // ==================================================
  // words[0] sits at the lowest address of the line
  typedef union packed {
    logic [LINE_BITS-1:0]                raw;
    logic [WORDS_PER_LINE-1:0][31:0]     words;
  } fetch_line_t;

endpackage

// File: fetch_line_ram.sv
`timescale 1ns/1ps

module fetch_line_ram
  import fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   wr_en_i,
  input  logic [FB_PTR_BITS-2:0] wr_addr_i,
  input  fetch_line_t            wr_line_i,
  input  logic [FB_PTR_BITS-2:0] rd_addr_i,
  output fetch_line_t            rd_line_o
);

  logic [LINE_BITS-1:0] mem [FB_DEPTH];

  // line storage
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_line_i.raw;
    end
  end

  // ==================================================
  // async read with write bypass
  // ==================================================
  // a line arriving this cycle is visible at once
  always_comb begin
    if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
      rd_line_o.raw = wr_line_i.raw;
    end else begin
      rd_line_o.raw = mem[rd_addr_i];
    end
  end

endmodule

// File: fetch_axi_reader.sv
`timescale 1ns/1ps

module fetch_axi_reader
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_en_i,
  input  logic       flush_i,
  input  logic       ar_ready_i,
  output logic       ar_valid_o,
  input  logic       r_valid_i,
  input  logic [1:0] r_resp_i,
  output logic       r_ready_o,
  output logic       line_wr_o
);

  logic       state_q;
  logic       state_d;
  logic       stale_q;
  logic [1:0] last_resp_q;
  logic       ar_fire;
  logic       r_fire;

  // ==================================================
  // handshakes
  // ==================================================
  assign ar_valid_o = (state_q == RD_IDLE) && req_en_i;
  assign r_ready_o  = (state_q == RD_WAIT);

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_o;

  // ==================================================
  // idle / wait-response FSM
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (ar_fire) begin
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (r_fire) begin
          state_d = RD_IDLE;
        end
      end
      default: begin
        state_d = RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // redirect while waiting, the line in flight is no longer wanted
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale_q <= 1'b0;
    end else if (r_fire) begin
      stale_q <= 1'b0;
    end else if (r_ready_o && flush_i) begin
      stale_q <= 1'b1;
    end
  end

  // last response code, kept for debug only
  always_ff @(posedge clk) begin
    if (r_fire) begin
      last_resp_q <= r_resp_i;
    end
  end

  assign line_wr_o = r_fire && !flush_i && !stale_q;

endmodule

// File: fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush_i,
  input  logic [XLEN-1:0] pc_i,
  // cache read port
  input  logic            ar_ready_i,
  output logic            ar_valid_o,
  output logic [XLEN-1:0] ar_addr_o,
  input  logic            r_valid_i,
  input  fetch_line_t     r_data_i,
  input  logic [1:0]      r_resp_i,
  output logic            r_ready_o,
  // decode side
  output logic            inst_valid_o,
  output logic [31:0]     inst_o
);

  logic [FB_PTR_BITS-1:0]     wr_ptr_q;
  logic [FB_PTR_BITS-1:0]     rd_ptr_q;
  logic [FB_PTR_BITS-1:0]     req_cnt_q;
  logic [FB_PTR_BITS-1:0]     occupancy;
  logic [FB_PTR_BITS-1:0]     avail;
  logic [FB_PTR_BITS-1:0]     need;
  logic [XLEN-1:LINE_OFFSET]  head_line_q;
  logic [XLEN-1:LINE_OFFSET]  pc_line;
  logic [XLEN-1:LINE_OFFSET]  req_line;
  logic [FB_PTR_BITS-2:0]     rd_addr;
  logic                       full;
  logic                       empty;
  logic                       pc_in_head;
  logic                       pc_in_next;
  logic                       pop;
  logic                       line_wr;
  logic                       ar_fire;
  fetch_line_t                rd_line;

  // ==================================================
  // occupancy
  // ==================================================
  assign occupancy = wr_ptr_q - rd_ptr_q;
  assign empty     = (wr_ptr_q == rd_ptr_q);
  assign full      = (rd_ptr_q == {~wr_ptr_q[FB_PTR_BITS-1], wr_ptr_q[FB_PTR_BITS-2:0]});

  // where the pc sits relative to the head line
  assign pc_line    = pc_i[XLEN-1:LINE_OFFSET];
  assign pc_in_head = (pc_line == head_line_q);
  assign pc_in_next = (pc_line == head_line_q + 1'b1);

  // the in-flight line always lands at head + occupancy
  assign avail = occupancy + FB_PTR_BITS'(line_wr);
  assign need  = FB_PTR_BITS'(!pc_in_head);

  // pc stepped past the head line, drop it
  assign pop = !flush_i && pc_in_next && !empty;

  // ==================================================
  // instruction select
  // ==================================================
  assign rd_addr = rd_ptr_q[FB_PTR_BITS-2:0] + (FB_PTR_BITS-1)'(!pc_in_head);

  assign inst_valid_o = !flush_i && (pc_in_head || pc_in_next) && (need < avail);
  assign inst_o       = rd_line.words[pc_i[LINE_OFFSET-1:2]];

  // ==================================================
  // request address
  // ==================================================
  // next line is head plus lines already asked for
  assign req_line  = flush_i ? pc_line : head_line_q + (XLEN-LINE_OFFSET)'(req_cnt_q);
  assign ar_addr_o = {req_line, {LINE_OFFSET{1'b0}}};
  assign ar_fire   = ar_valid_o && ar_ready_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
    end else if (line_wr) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_ptr_q    <= '0;
      head_line_q <= RESET_PC[XLEN-1:LINE_OFFSET];
    end else if (flush_i) begin
      rd_ptr_q    <= wr_ptr_q;
      head_line_q <= pc_line;
    end else if (pop) begin
      rd_ptr_q    <= rd_ptr_q + 1'b1;
      head_line_q <= head_line_q + 1'b1;
    end
  end

  // lines buffered or in flight, counted from the head
  always_ff @(posedge clk) begin
    if (rst_n) begin
      req_cnt_q <= '0;
    end else if (flush_i) begin
      req_cnt_q <= FB_PTR_BITS'(ar_fire);
    end else begin
      req_cnt_q <= req_cnt_q + FB_PTR_BITS'(ar_fire) - FB_PTR_BITS'(pop);
    end
  end

  fetch_line_ram i_line_ram (
    .clk       (clk),
    .wr_en_i   (line_wr),
    .wr_addr_i (wr_ptr_q[FB_PTR_BITS-2:0]),
    .wr_line_i (r_data_i),
    .rd_addr_i (rd_addr),
    .rd_line_o (rd_line)
  );

  fetch_axi_reader i_axi_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_en_i   (!full || flush_i),
    .flush_i    (flush_i),
    .ar_ready_i (ar_ready_i),
    .ar_valid_o (ar_valid_o),
    .r_valid_i  (r_valid_i),
    .r_resp_i   (r_resp_i),
    .r_ready_o  (r_ready_o),
    .line_wr_o  (line_wr)
  );

endmodule

// File: ifu_pc_gen.sv
`timescale 1ns/1ps

module ifu_pc_gen
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            stall_i,
  input  logic            inst_valid_i,
  output logic [XLEN-1:0] pc_o,
  output logic            flush_o
);

  logic [XLEN-1:0] pc_q;

  // ==================================================
  // pc register
  // ==================================================
  // redirect wins over a sequential step
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (inst_valid_i && !stall_i) begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

  // target shows early so the buffer can request its line at once
  assign pc_o = redirect_i ? redirect_pc_i : pc_q;

  // flush is the redirect itself
  assign flush_o = redirect_i;

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  // branch / jump
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            stall_i,
  // cache read port
  input  logic            ar_ready_i,
  output logic            ar_valid_o,
  output logic [XLEN-1:0] ar_addr_o,
  input  logic            r_valid_i,
  input  fetch_line_t     r_data_i,
  input  logic [1:0]      r_resp_i,
  output logic            r_ready_o,
  // decode side
  output logic            inst_valid_o,
  output logic [31:0]     inst_o,
  output logic [XLEN-1:0] inst_pc_o
);

  logic [XLEN-1:0] pc;
  logic            flush;

  // ==================================================
  // pc generator and prefetch buffer
  // ==================================================
  ifu_pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .inst_valid_i  (inst_valid_o),
    .pc_o          (pc),
    .flush_o       (flush)
  );

  fetch_buffer i_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .pc_i         (pc),
    .ar_ready_i   (ar_ready_i),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .r_ready_o    (r_ready_o),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

  assign inst_pc_o = pc;

endmodule

// File: fetch_props.sv
`timescale 1ns/1ps

module fetch_props
  import fetch_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   flush_i,
  input logic                   ar_valid_i,
  input logic                   ar_ready_i,
  input logic                   r_valid_i,
  input logic                   r_ready_i,
  input logic                   full_i,
  input logic [FB_PTR_BITS-1:0] occupancy_i
);

  // ==================================================
  // read address channel
  // ==================================================
  // request stays up until accepted
  ar_held: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i || flush_i || full_i)
    else $error("ar_valid dropped before the address was accepted");

  // ==================================================
  // read data channel
  // ==================================================
  // back to idle once the line is taken
  r_ready_drops: assert property (@(posedge clk) disable iff (rst_n)
    r_ready_i && r_valid_i |=> !r_ready_i)
    else $error("r_ready still high after the response transfer");

  r_ready_after_ar: assert property (@(posedge clk) disable iff (rst_n)
    $rose(r_ready_i) |-> $past(ar_valid_i && ar_ready_i))
    else $error("r_ready rose without an address transfer");

  // occupancy
  occupancy_in_range: assert property (@(posedge clk) disable iff (rst_n)
    occupancy_i <= FB_PTR_BITS'(FB_DEPTH))
    else $error("buffer holds more lines than it has entries");

endmodule

// File: tb_icache_model.sv
`timescale 1ns/1ps

module tb_icache_model
  import fetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ar_valid_i,
  input  logic [XLEN-1:0]      ar_addr_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  output logic [LINE_BITS-1:0] r_data_o,
  output logic [1:0]           r_resp_o,
  input  logic                 r_ready_i
);

  integer          seed;
  int unsigned     delay;
  logic            busy_q;
  logic            phase_start_q;
  logic [XLEN-1:0] addr_q;

  initial begin
    seed       = 32'h41df_2237;
    delay      = 0;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = 2'b00;
  end

  // 0 to 5 cycles before each ready or valid
  function automatic int unsigned pick_delay();
    return $unsigned($random(seed)) % 6;
  endfunction

  // every word is its own byte address with the top byte inverted
  function automatic logic [LINE_BITS-1:0] line_data(input logic [XLEN-1:0] addr);
    logic [LINE_BITS-1:0] data;
    logic [XLEN-1:0]      word_addr;
    data = '0;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      word_addr = {addr[XLEN-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}} + XLEN'(4 * i);
      data[32*i +: 32] = word_addr ^ 32'hff00_0000;
    end
    return data;
  endfunction

  // ==================================================
  // transfers seen on the rising edge
  // ==================================================
  always @(posedge clk) begin
    if (rst_n) begin
      busy_q        <= 1'b0;
      phase_start_q <= 1'b1;
    end else if (!busy_q && ar_valid_i && ar_ready_o) begin
      busy_q        <= 1'b1;
      addr_q        <= ar_addr_i;
      phase_start_q <= 1'b1;
    end else if (busy_q && r_valid_o && r_ready_i) begin
      busy_q        <= 1'b0;
      phase_start_q <= 1'b1;
    end else begin
      phase_start_q <= 1'b0;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    if (phase_start_q) begin
      delay = pick_delay();
    end
    if (delay != 0) begin
      delay = delay - 1;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
    end else begin
      ar_ready_o <= !busy_q;
      r_valid_o  <= busy_q;
      r_data_o   <= busy_q ? line_data(addr_q) : '0;
    end
  end

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 2;
  localparam int TIMEOUT_MARGIN = 2000;

  typedef struct packed {
    int unsigned cycles;
    int unsigned stall_pct;
    bit          redir;
    logic [31:0] target;
    int unsigned gapless;
    bit          must_fetch;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 redirect_i;
  logic [XLEN-1:0]      redirect_pc_i;
  logic                 stall_i;
  logic                 ar_ready;
  logic                 ar_valid;
  logic [XLEN-1:0]      ar_addr;
  logic                 r_valid;
  logic [LINE_BITS-1:0] r_data;
  logic [1:0]           r_resp;
  logic                 r_ready;
  logic                 inst_valid_o;
  logic [31:0]          inst_o;
  logic [XLEN-1:0]      inst_pc_o;

  row_t            rows[$];
  bit              table_ready;
  integer          seed;
  logic [XLEN-1:0] ref_pc;
  bit              hold_pending;
  int unsigned     row_valid;

  fetch_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .ar_ready_i    (ar_ready),
    .ar_valid_o    (ar_valid),
    .ar_addr_o     (ar_addr),
    .r_valid_i     (r_valid),
    .r_data_i      (r_data),
    .r_resp_i      (r_resp),
    .r_ready_o     (r_ready),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o)
  );

  tb_icache_model i_icache (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .r_ready_i  (r_ready)
  );

  bind fetch_buffer fetch_props i_fetch_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .ar_valid_i  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_ready_i   (r_ready_o),
    .full_i      (full),
    .occupancy_i (occupancy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // instruction rule of the cache model
  function automatic logic [31:0] expected_word(input logic [XLEN-1:0] pc);
    return pc ^ 32'hff00_0000;
  endfunction

  task automatic add_row(input int unsigned cycles, input int unsigned stall_pct,
                         input bit redir, input logic [31:0] target,
                         input int unsigned gapless, input bit must_fetch);
    row_t row;
    row.cycles     = cycles;
    row.stall_pct  = stall_pct;
    row.redir      = redir;
    row.target     = target;
    row.gapless    = gapless;
    row.must_fetch = must_fetch;
    rows.push_back(row);
  endtask

  // cache read port and decode side in the first cycle after reset
  task automatic check_after_reset();
    @(posedge clk);
    check_equal(32'(ar_valid), 32'd1, "ar_valid in the first cycle after reset");
    check_equal(ar_addr, RESET_PC, "first request address");
    check_equal(32'(r_ready), 32'd0, "r_ready in the first cycle after reset");
    check_equal(32'(inst_valid_o), 32'd0, "inst_valid in the first cycle after reset");
    @(negedge clk);
  endtask

  // ==================================================
  // reference pc model and checks at the rising edge
  // ==================================================
  task automatic observe_cycle(input bit need_valid);
    if (redirect_i) begin
      check_equal(32'(inst_valid_o), 32'd0, "valid during redirect");
      ref_pc       = redirect_pc_i;
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        check_equal(32'(inst_valid_o), 32'd1, "stalled instruction lost");
      end
      if (need_valid) begin
        check_equal(32'(inst_valid_o), 32'd1, "gap in instruction stream");
      end
      if (inst_valid_o) begin
        check_equal(inst_pc_o, ref_pc, "instruction pc");
        check_equal(inst_o, expected_word(ref_pc), "instruction data");
        row_valid = row_valid + 1;
        if (!stall_i) begin
          ref_pc = ref_pc + 32'd4;
        end
      end
      hold_pending = inst_valid_o && stall_i;
    end
  endtask

  // runs from one falling edge to the next
  task automatic run_cycle(input bit redir, input logic [31:0] target,
                           input int unsigned stall_pct, input bit need_valid);
    redirect_i    = redir;
    redirect_pc_i = redir ? target : '0;
    stall_i       = ($unsigned($random(seed)) % 100) < stall_pct;
    @(posedge clk);
    observe_cycle(need_valid);
    @(negedge clk);
  endtask

  // cycles, stall %, redirect, target, gapless cycles, must fetch
  task automatic build_table();
    add_row(40,  0,   0, 32'h0,         0,  1);
    add_row(80,  30,  0, 32'h0,         0,  1);
    add_row(40,  0,   1, 32'h8000_1238, 0,  1);
    add_row(3,   0,   1, 32'h8000_2000, 0,  0);
    add_row(2,   0,   1, 32'h8000_3004, 0,  0);
    add_row(50,  20,  1, 32'h8000_0ff8, 0,  1);
    // long stall fills the buffer and the resume drains it
    add_row(70,  100, 0, 32'h0,         0,  1);
    add_row(40,  0,   0, 32'h0,         12, 1);
    add_row(1,   0,   1, 32'h8000_400c, 0,  0);
    add_row(60,  50,  1, 32'h8000_500c, 0,  1);
    add_row(60,  100, 0, 32'h0,         0,  1);
    add_row(50,  0,   0, 32'h0,         12, 1);
    add_row(100, 40,  0, 32'h0,         0,  1);
  endtask

  initial begin
    rst_n         = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    seed          = 32'h41df_2237;
    ref_pc        = RESET_PC;
    hold_pending  = 1'b0;
    row_valid     = 0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b0;
    check_after_reset();
    for (int r = 0; r < rows.size(); r++) begin
      row_valid = 0;
      if (rows[r].redir) begin
        run_cycle(1'b1, rows[r].target, rows[r].stall_pct, 1'b0);
      end
      for (int unsigned cyc = 0; cyc < rows[r].cycles; cyc++) begin
        run_cycle(1'b0, 32'h0, rows[r].stall_pct, cyc < rows[r].gapless);
      end
      if (rows[r].must_fetch) begin
        check_equal(32'(row_valid != 0), 32'd1, "no instruction delivered in row");
      end
    end
    $display("Regression passed");
    $finish;
  end

  // ==================================================
  // watchdog
  // ==================================================
  initial begin : watchdog
    int unsigned total;
    wait (table_ready);
    total = RESET_CYCLES + 1;
    for (int r = 0; r < rows.size(); r++) begin
      total = total + rows[r].cycles + 1;
    end
    #(total * CLK_PERIOD + TIMEOUT_MARGIN);
    $display("the run timed out before all stimulus rows were applied");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: fetch_top.f
fetch_pkg.sv
fetch_line_ram.sv
fetch_axi_reader.sv
fetch_buffer.sv
ifu_pc_gen.sv
fetch_top.sv
fetch_props.sv
tb_icache_model.sv
tb_fetch_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fetch_top
FILELIST = fetch_top.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
